/* common/cameraPkg.sv */
package cameraPkg;

  // widths with a meaning.
  typedef logic [10:0] byteCountT;
  typedef logic [7:0]  wordAddrT;
  typedef logic [31:0] busWordT;
  typedef logic [16:0] pclkKhzT;
  typedef logic [7:0]  fpsT;

  typedef enum logic [2:0] {
    idle,
    requestBus,
    initBurst,
    doBurst,
    endOk,
    endError
  } burstStateT;

  // custom instruction codes in ciValueA.
  localparam logic [2:0] cmdLineBytes  = 3'd0;
  localparam logic [2:0] cmdFrameLines = 3'd1;
  localparam logic [2:0] cmdPclkKhz    = 3'd2;
  localparam logic [2:0] cmdFps        = 3'd3;
  localparam logic [2:0] cmdReadBase   = 3'd4;
  localparam logic [2:0] cmdWriteBase  = 3'd5;
  localparam logic [2:0] cmdControl    = 3'd6;
  localparam logic [2:0] cmdShotDone   = 3'd7;

  localparam int maxBurstWords = 16;

  // luma weights 77/150/29 over 256.
  function automatic logic [7:0] rgb565ToGray(input logic [15:0] rgb);
    logic [15:0] red;
    logic [15:0] green;
    logic [15:0] blue;
    logic [15:0] sum;
    red   = {8'd0, rgb[15:11], 3'd0};
    green = {8'd0, rgb[10:5], 2'd0};
    blue  = {8'd0, rgb[4:0], 3'd0};
    sum   = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
    return sum[15:8];
  endfunction

endpackage

/* common/grabberCfgIf.sv */
`timescale 1ns/1ps

interface grabberCfgIf import cameraPkg::*; ();

  // set by software through the register block.
  busWordT frameBase;
  logic    grabActive;
  logic    shotRequest;

  // single-cycle events from the burst controller.
  logic    shotFinished;
  logic    shotConsumed;

  modport regs (
    output frameBase,
    output grabActive,
    output shotRequest,
    input  shotFinished,
    input  shotConsumed
  );

  modport ctrl (
    input  frameBase,
    input  grabActive,
    input  shotRequest,
    output shotFinished,
    output shotConsumed
  );

endinterface

/* src/pulseSync.sv */
`timescale 1ns/1ps

module pulseSync
(
  input  logic srcClock,
  input  logic dstClock,
  input  logic arstN,
  input  logic srcPulse,
  output logic dstPulse
);

  logic       srcToggle;
  logic [2:0] dstSync;

  // each strobe flips the level.
  always_ff @(posedge srcClock or negedge arstN)
  begin
    if (!arstN)
      srcToggle <= 1'b0;
    else if (srcPulse)
      srcToggle <= ~srcToggle;
  end

  // two sync stages, third one for the edge.
  always_ff @(posedge dstClock or negedge arstN)
  begin
    if (!arstN)
      dstSync <= '0;
    else
      dstSync <= {dstSync[1:0], srcToggle};
  end

  assign dstPulse = dstSync[2] ^ dstSync[1];

endmodule

/* src/rateMeter.sv */
`timescale 1ns/1ps

module rateMeter
#(
  parameter int clockFrequencyInHz = 50000000
)
(
  input  logic clock,
  input  logic arstN,
  output logic khzTick,
  output logic hzTick
);

  localparam int khzDivide = clockFrequencyInHz / 1000;
  localparam int khzBits   = $clog2(khzDivide + 1);

  logic [khzBits-1:0] khzCount;
  logic [9:0]         hzCount;

  assign khzTick = (khzCount == '0);
  assign hzTick  = khzTick && (hzCount == 10'd0);

  // counts down so the tick falls on zero.
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      khzCount <= khzBits'(khzDivide - 1);
      hzCount  <= 10'd999;
    end
    else
    begin
      if (khzTick)
        khzCount <= khzBits'(khzDivide - 1);
      else
        khzCount <= khzCount - 1'b1;
      // 1000 kHz ticks per second.
      if (khzTick)
      begin
        if (hzCount == 10'd0)
          hzCount <= 10'd999;
        else
          hzCount <= hzCount - 10'd1;
      end
    end
  end

endmodule

/* capture/pixelCapture.sv */
`timescale 1ns/1ps

module pixelCapture import cameraPkg::*;
(
  input  logic       pclk,
  input  logic       arstN,
  input  logic       hsync,
  input  logic       vsync,
  input  logic [7:0] camData,
  input  logic       sampleKhz,
  input  logic       sampleHz,
  output logic       writeEnable,
  output wordAddrT   writeAddr,
  output busWordT    writeData,
  output logic       lineDoneRaw,
  output logic       frameStartRaw,
  output byteCountT  lineBytes,
  output byteCountT  frameLines,
  output pclkKhzT    pclkKhz,
  output fpsT        fps
);

  logic      hsyncPrev;
  logic      vsyncPrev;
  logic      hsyncFall;
  logic      vsyncFall;
  byteCountT byteCount;
  byteCountT lineCount;
  pclkKhzT   pclkCount;
  fpsT       frameCount;
  logic [7:0] groupBytes [7];
  logic [7:0] grayPixel [4];

  assign hsyncFall = hsyncPrev & ~hsync;
  assign vsyncFall = vsyncPrev & ~vsync;

  // ==========================================================================
  // line and frame measurement
  // ==========================================================================

  always_ff @(posedge pclk or negedge arstN)
  begin
    if (!arstN)
    begin
      hsyncPrev     <= 1'b0;
      vsyncPrev     <= 1'b0;
      lineDoneRaw   <= 1'b0;
      frameStartRaw <= 1'b0;
      byteCount     <= '0;
      lineCount     <= '0;
      lineBytes     <= '0;
      frameLines    <= '0;
    end
    else
    begin
      hsyncPrev     <= hsync;
      vsyncPrev     <= vsync;
      lineDoneRaw   <= hsyncFall;
      frameStartRaw <= vsyncFall;
      if (hsyncFall)
      begin
        lineBytes <= byteCount;
        byteCount <= '0;
      end
      else if (hsync)
        byteCount <= byteCount + 11'd1;
      // line count restarts with every frame.
      if (vsyncFall)
      begin
        frameLines <= lineCount;
        lineCount  <= '0;
      end
      else if (hsyncFall)
        lineCount <= lineCount + 11'd1;
    end
  end

  // pclk cycles per kHz tick and frames per Hz tick.
  always_ff @(posedge pclk or negedge arstN)
  begin
    if (!arstN)
    begin
      pclkCount  <= '0;
      pclkKhz    <= '0;
      frameCount <= '0;
      fps        <= '0;
    end
    else
    begin
      if (sampleKhz)
      begin
        pclkKhz   <= pclkCount + 17'd1;
        pclkCount <= '0;
      end
      else
        pclkCount <= pclkCount + 17'd1;
      if (sampleHz)
      begin
        fps        <= frameCount;
        frameCount <= vsyncFall ? 8'd1 : 8'd0;
      end
      else if (vsyncFall)
        frameCount <= frameCount + 8'd1;
    end
  end

  // ==========================================================================
  // byte packing
  // ==========================================================================

  // first seven bytes of a group; the eighth is taken live.
  always_ff @(posedge pclk)
  begin
    if (hsync && (byteCount[2:0] != 3'd7))
      groupBytes[byteCount[2:0]] <= camData;
  end

  assign grayPixel[0] = rgb565ToGray({groupBytes[0], groupBytes[1]});
  assign grayPixel[1] = rgb565ToGray({groupBytes[2], groupBytes[3]});
  assign grayPixel[2] = rgb565ToGray({groupBytes[4], groupBytes[5]});
  assign grayPixel[3] = rgb565ToGray({groupBytes[6], camData});

  // pixel k of the group lands in byte lane k.
  assign writeData   = {grayPixel[3], grayPixel[2], grayPixel[1], grayPixel[0]};
  assign writeEnable = hsync && (byteCount[2:0] == 3'd7);
  assign writeAddr   = byteCount[10:3];

endmodule

/* capture/lineBuffer.sv */
`timescale 1ns/1ps

module lineBuffer import cameraPkg::*;
(
  input  logic     pclk,
  input  logic     writeEnable,
  input  wordAddrT writeAddr,
  input  busWordT  writeData,
  input  logic     clock,
  input  wordAddrT readAddr,
  output busWordT  readData
);

  // one line of packed gray pixels.
  busWordT lineMem [256];

  always_ff @(posedge pclk)
  begin
    if (writeEnable)
      lineMem[writeAddr] <= writeData;
  end

  // registered read in the system clock domain.
  always_ff @(posedge clock)
  begin
    readData <= lineMem[readAddr];
  end

endmodule

/* src/ciRegisters.sv */
`timescale 1ns/1ps

module ciRegisters import cameraPkg::*;
#(
  parameter logic [7:0] customInstructionId = 8'd0
)
(
  input  logic       clock,
  input  logic       arstN,
  input  logic       ciStart,
  input  logic       ciCke,
  input  logic [7:0] ciN,
  input  busWordT    ciValueA,
  input  busWordT    ciValueB,
  input  byteCountT  lineBytes,
  input  byteCountT  frameLines,
  input  pclkKhzT    pclkKhz,
  input  fpsT        fps,
  output busWordT    ciResult,
  output logic       ciDone,
  grabberCfgIf.regs  cfg
);

  logic       selected;
  logic       cmdValid;
  logic [2:0] command;
  logic       shotDone;
  busWordT    readValue;

  assign selected = ciStart && ciCke && (ciN == customInstructionId);
  assign cmdValid = (ciValueA[31:3] == '0);
  assign command  = ciValueA[2:0];

  assign ciDone   = selected;
  assign ciResult = selected ? readValue : '0;

  // ==========================================================================
  // configuration registers
  // ==========================================================================

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      cfg.frameBase   <= '0;
      cfg.grabActive  <= 1'b0;
      cfg.shotRequest <= 1'b0;
      shotDone        <= 1'b0;
    end
    else
    begin
      if (selected && cmdValid && (command == cmdWriteBase))
        cfg.frameBase <= {ciValueB[31:2], 2'b00};
      if (selected && cmdValid && (command == cmdControl))
        cfg.grabActive <= (ciValueB[1:0] == 2'b01);
      // a request stays pending until a frame start takes it.
      if (selected && cmdValid && (command == cmdControl) && (ciValueB[1:0] == 2'b10))
        cfg.shotRequest <= 1'b1;
      else if (cfg.shotConsumed)
        cfg.shotRequest <= 1'b0;
      // finish beats a read in the same cycle.
      if (cfg.shotFinished)
        shotDone <= 1'b1;
      else if (selected && cmdValid && (command == cmdShotDone))
        shotDone <= 1'b0;
    end
  end

  // measurements are quasi-static, read straight across.
  always_comb
  begin
    readValue = '0;
    if (cmdValid)
    begin
      case (command)
        cmdLineBytes:  readValue = busWordT'(lineBytes);
        cmdFrameLines: readValue = busWordT'(frameLines);
        cmdPclkKhz:    readValue = busWordT'(pclkKhz);
        cmdFps:        readValue = busWordT'(fps);
        cmdReadBase:   readValue = cfg.frameBase;
        cmdShotDone:   readValue = busWordT'(shotDone);
        default:       readValue = '0;
      endcase
    end
  end

endmodule

/* src/burstControl.sv */
`timescale 1ns/1ps

module burstControl import cameraPkg::*;
(
  input  logic       clock,
  input  logic       arstN,
  input  logic       lineDone,
  input  logic       frameStart,
  input  byteCountT  lineBytes,
  input  logic       busGrant,
  input  logic       busy,
  input  logic       busError,
  input  busWordT    readData,
  output wordAddrT   readAddr,
  output logic       requestBus,
  output logic       beginTransaction,
  output busWordT    addressData,
  output logic       endTransaction,
  output logic [3:0] byteEnables,
  output logic       dataValid,
  output logic [7:0] burstSize,
  grabberCfgIf.ctrl  cfg
);

  burstStateT state;
  burstStateT nextState;
  logic       grabRunning;
  logic       shotArmed;
  busWordT    busAddr;
  logic [7:0] lineWords;
  logic [7:0] wordsLeft;
  logic [7:0] burstWords;
  logic [4:0] burstLeft;
  wordAddrT   readPtr;
  logic       doWrite;
  logic       burstDone;
  logic       lineAccepted;

  assign lineWords  = 8'(lineBytes >> 3);
  assign burstWords = (wordsLeft > 8'(maxBurstWords)) ? 8'(maxBurstWords) : wordsLeft;

  // one word per cycle without back-pressure.
  assign doWrite   = (state == doBurst) && (burstLeft != 5'd0) && !busy && !busError;
  assign burstDone = (state == doBurst) && (burstLeft == 5'd0) && !busy;

  // look one word ahead for the registered line buffer read.
  assign readAddr = doWrite ? readPtr + 8'd1 : readPtr;

  assign requestBus   = (state == cameraPkg::requestBus);
  assign lineAccepted = (state == idle) && (nextState == cameraPkg::requestBus);

  // shot bookkeeping happens at frame boundaries.
  assign cfg.shotConsumed = frameStart && cfg.shotRequest;
  assign cfg.shotFinished = frameStart && shotArmed;

  // ==========================================================================
  // control FSM
  // ==========================================================================

  always_comb
  begin
    nextState = state;
    case (state)
      idle:
        if (lineDone && (grabRunning || shotArmed) && (lineWords != 8'd0))
          nextState = cameraPkg::requestBus;
      cameraPkg::requestBus:
        if (busGrant)
          nextState = initBurst;
      initBurst:
        nextState = doBurst;
      doBurst:
        if (busError)
          nextState = endError;
        else if (burstDone)
          nextState = endOk;
      endOk:
        nextState = (wordsLeft != 8'd0) ? cameraPkg::requestBus : idle;
      default:
        nextState = idle;
    endcase
  end

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      state       <= idle;
      grabRunning <= 1'b0;
      shotArmed   <= 1'b0;
      busAddr     <= '0;
      wordsLeft   <= '0;
      burstLeft   <= '0;
      readPtr     <= '0;
    end
    else
    begin
      state <= nextState;
      if (frameStart)
      begin
        busAddr     <= cfg.frameBase;
        grabRunning <= cfg.grabActive;
        shotArmed   <= cfg.shotRequest;
      end
      else if (doWrite)
        busAddr <= busAddr + 32'd4;
      if (lineAccepted)
      begin
        wordsLeft <= lineWords;
        readPtr   <= '0;
      end
      else if (state == initBurst)
      begin
        wordsLeft <= wordsLeft - burstWords;
        burstLeft <= burstWords[4:0];
      end
      else if (doWrite)
      begin
        burstLeft <= burstLeft - 5'd1;
        readPtr   <= readAddr;
      end
      else if (state == endError)
        wordsLeft <= '0;
    end
  end

  // ==========================================================================
  // bus outputs
  // ==========================================================================

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      beginTransaction <= 1'b0;
      endTransaction   <= 1'b0;
      byteEnables      <= '0;
      burstSize        <= '0;
      addressData      <= '0;
      dataValid        <= 1'b0;
    end
    else
    begin
      beginTransaction <= (state == initBurst);
      byteEnables      <= (state == initBurst) ? 4'hF : 4'h0;
      burstSize        <= (state == initBurst) ? burstWords - 8'd1 : 8'd0;
      endTransaction   <= burstDone || ((state == doBurst) && busError);
      if (state == initBurst)
      begin
        addressData <= busAddr;
        dataValid   <= 1'b0;
      end
      else if (doWrite)
      begin
        addressData <= readData;
        dataValid   <= 1'b1;
      end
      else if (!busy || busError)
      begin
        addressData <= '0;
        dataValid   <= 1'b0;
      end
    end
  end

endmodule

/* src/cameraGrabber.sv */
`timescale 1ns/1ps

module cameraGrabber import cameraPkg::*;
#(
  parameter logic [7:0] customInstructionId = 8'd0,
  parameter int         clockFrequencyInHz  = 50000000
)
(
  input  logic       clock,
  input  logic       arstN,
  input  logic       pclk,
  input  logic       hsync,
  input  logic       vsync,
  input  logic [7:0] camData,
  input  logic       ciStart,
  input  logic       ciCke,
  input  logic [7:0] ciN,
  input  busWordT    ciValueA,
  input  busWordT    ciValueB,
  input  logic       busGrant,
  input  logic       busy,
  input  logic       busError,
  output busWordT    ciResult,
  output logic       ciDone,
  output logic       requestBus,
  output logic       beginTransaction,
  output busWordT    addressData,
  output logic       endTransaction,
  output logic [3:0] byteEnables,
  output logic       dataValid,
  output logic [7:0] burstSize
);

  // pclk domain.
  logic      writeEnable;
  wordAddrT  writeAddr;
  busWordT   writeData;
  logic      lineDoneRaw;
  logic      frameStartRaw;
  byteCountT lineBytes;
  byteCountT frameLines;
  pclkKhzT   pclkKhz;
  fpsT       fps;
  logic      sampleKhz;
  logic      sampleHz;

  // system clock domain.
  logic      khzTick;
  logic      hzTick;
  logic      lineDone;
  logic      frameStart;
  wordAddrT  readAddr;
  busWordT   readData;

  grabberCfgIf cfgBus ();

  pixelCapture capture (
    .pclk          (pclk),
    .arstN         (arstN),
    .hsync         (hsync),
    .vsync         (vsync),
    .camData       (camData),
    .sampleKhz     (sampleKhz),
    .sampleHz      (sampleHz),
    .writeEnable   (writeEnable),
    .writeAddr     (writeAddr),
    .writeData     (writeData),
    .lineDoneRaw   (lineDoneRaw),
    .frameStartRaw (frameStartRaw),
    .lineBytes     (lineBytes),
    .frameLines    (frameLines),
    .pclkKhz       (pclkKhz),
    .fps           (fps)
  );

  lineBuffer buffer (
    .pclk        (pclk),
    .writeEnable (writeEnable),
    .writeAddr   (writeAddr),
    .writeData   (writeData),
    .clock       (clock),
    .readAddr    (readAddr),
    .readData    (readData)
  );

  rateMeter #(
    .clockFrequencyInHz (clockFrequencyInHz)
  ) rates (
    .clock   (clock),
    .arstN   (arstN),
    .khzTick (khzTick),
    .hzTick  (hzTick)
  );

  // camera events into the system clock.
  pulseSync lineDoneSync (
    .srcClock (pclk),
    .dstClock (clock),
    .arstN    (arstN),
    .srcPulse (lineDoneRaw),
    .dstPulse (lineDone)
  );

  pulseSync frameStartSync (
    .srcClock (pclk),
    .dstClock (clock),
    .arstN    (arstN),
    .srcPulse (frameStartRaw),
    .dstPulse (frameStart)
  );

  // measurement ticks into pclk.
  pulseSync khzSync (
    .srcClock (clock),
    .dstClock (pclk),
    .arstN    (arstN),
    .srcPulse (khzTick),
    .dstPulse (sampleKhz)
  );

  pulseSync hzSync (
    .srcClock (clock),
    .dstClock (pclk),
    .arstN    (arstN),
    .srcPulse (hzTick),
    .dstPulse (sampleHz)
  );

  ciRegisters #(
    .customInstructionId (customInstructionId)
  ) registers (
    .clock      (clock),
    .arstN      (arstN),
    .ciStart    (ciStart),
    .ciCke      (ciCke),
    .ciN        (ciN),
    .ciValueA   (ciValueA),
    .ciValueB   (ciValueB),
    .lineBytes  (lineBytes),
    .frameLines (frameLines),
    .pclkKhz    (pclkKhz),
    .fps        (fps),
    .ciResult   (ciResult),
    .ciDone     (ciDone),
    .cfg        (cfgBus.regs)
  );

  burstControl control (
    .clock            (clock),
    .arstN            (arstN),
    .lineDone         (lineDone),
    .frameStart       (frameStart),
    .lineBytes        (lineBytes),
    .busGrant         (busGrant),
    .busy             (busy),
    .busError         (busError),
    .readData         (readData),
    .readAddr         (readAddr),
    .requestBus       (requestBus),
    .beginTransaction (beginTransaction),
    .addressData      (addressData),
    .endTransaction   (endTransaction),
    .byteEnables      (byteEnables),
    .dataValid        (dataValid),
    .burstSize        (burstSize),
    .cfg              (cfgBus.ctrl)
  );

endmodule

/* tests/cameraGrabberTb.sv */
`timescale 1ns/1ps

module cameraGrabberTb;

  localparam int clockHz       = 125000;
  localparam int khzCycles     = clockHz / 1000;
  localparam int ciId          = 5;
  localparam int bytesPerLine  = 48;
  localparam int linesPerFrame = 4;
  localparam int wordsPerLine  = bytesPerLine / 8;
  localparam int maxBurst      = 16;
  localparam int drainTimeout  = 5000;

  // custom instruction codes.
  localparam logic [31:0] opLineBytes  = 32'd0;
  localparam logic [31:0] opFrameLines = 32'd1;
  localparam logic [31:0] opPclkKhz    = 32'd2;
  localparam logic [31:0] opFps        = 32'd3;
  localparam logic [31:0] opReadBase   = 32'd4;
  localparam logic [31:0] opWriteBase  = 32'd5;
  localparam logic [31:0] opControl    = 32'd6;
  localparam logic [31:0] opShotDone   = 32'd7;

  logic        clock;
  logic        arstN;
  logic        pclk;
  logic        hsync;
  logic        vsync;
  logic [7:0]  camData;
  logic        ciStart;
  logic        ciCke;
  logic [7:0]  ciN;
  logic [31:0] ciValueA;
  logic [31:0] ciValueB;
  logic        busGrant;
  logic        busy;
  logic        busError;
  logic [31:0] ciResult;
  logic        ciDone;
  logic        requestBus;
  logic        beginTransaction;
  logic [31:0] addressData;
  logic        endTransaction;
  logic [3:0]  byteEnables;
  logic        dataValid;
  logic [7:0]  burstSize;

  logic [15:0] camLfsr;
  logic [15:0] slaveLfsr;
  logic [31:0] slaveDraw;
  logic [31:0] baseAddr;
  logic [31:0] expData [$];
  logic [31:0] expAddr [$];
  int          frameStarts [$];
  int          errorCount;
  int          cycleCount;
  int          slavePhase;
  int          grantDelay;
  bit          burstOpen;
  logic [31:0] curAddr;
  logic [7:0]  burstSizeSeen;
  int          wordsInBurst;
  int          lineWordsLeft;
  int          burstExpected;
  int          totalWords;
  int          beginCount;
  int          endCount;

  cameraGrabber #(
    .customInstructionId (8'(ciId)),
    .clockFrequencyInHz  (clockHz)
  ) u_dut (
    .clock            (clock),
    .arstN            (arstN),
    .pclk             (pclk),
    .hsync            (hsync),
    .vsync            (vsync),
    .camData          (camData),
    .ciStart          (ciStart),
    .ciCke            (ciCke),
    .ciN              (ciN),
    .ciValueA         (ciValueA),
    .ciValueB         (ciValueB),
    .busGrant         (busGrant),
    .busy             (busy),
    .busError         (busError),
    .ciResult         (ciResult),
    .ciDone           (ciDone),
    .requestBus       (requestBus),
    .beginTransaction (beginTransaction),
    .addressData      (addressData),
    .endTransaction   (endTransaction),
    .byteEnables      (byteEnables),
    .dataValid        (dataValid),
    .burstSize        (burstSize)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial
  begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  always @(posedge clock)
  begin
    if (arstN)
      cycleCount <= cycleCount + 1;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  // taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic drawBits(inout logic [15:0] state, input int count,
                          output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
      state = lfsrStep(state);
      value = {value[30:0], state[0]};
    end
  endtask

  // luma of one rgb565 pixel.
  function automatic logic [7:0] grayOf(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return 8'((77 * red + 150 * green + 29 * blue) / 256);
  endfunction

  function automatic bit withinTolerance(input logic [31:0] expected,
                                         input logic [31:0] actual,
                                         input int tolerance);
    return (actual + tolerance >= expected) && (actual <= expected + tolerance);
  endfunction

  function automatic int framesInWindow(input int first, input int last);
    int count;
    count = 0;
    foreach (frameStarts[i])
    begin
      if ((frameStarts[i] >= first) && (frameStarts[i] < last))
        count++;
    end
    return count;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      errorCount++;
      $display("ERROR at %0t ns: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  task automatic reportFailure(input string message);
    errorCount++;
    $display("at %0t ns: %s", $time, message);
  endtask

  // one selected or unselected instruction, sampled mid-cycle.
  task automatic issueInstruction(input logic [7:0] n, input logic [31:0] a,
                                  input logic [31:0] b, output logic [31:0] result,
                                  output logic done);
    @(posedge clock);
    ciStart  <= 1'b1;
    ciCke    <= 1'b1;
    ciN      <= n;
    ciValueA <= a;
    ciValueB <= b;
    @(negedge clock);
    result = ciResult;
    done   = ciDone;
    @(posedge clock);
    ciStart  <= 1'b0;
    ciCke    <= 1'b0;
    ciValueA <= '0;
    ciValueB <= '0;
  endtask

  // one camera frame; the model queues words when capture is on.
  task automatic sendFrame(input bit capture);
    logic [7:0]  lineData [bytesPerLine];
    logic [31:0] bits;
    logic [31:0] word;
    int          line;
    int          g;
    int          k;
    @(posedge pclk);
    vsync <= 1'b1;
    repeat (4) @(posedge pclk);
    vsync <= 1'b0;
    frameStarts.push_back(cycleCount);
    repeat (20) @(posedge pclk);
    for (line = 0; line < linesPerFrame; line++)
    begin
      for (k = 0; k < bytesPerLine; k++)
      begin
        drawBits(camLfsr, 8, bits);
        lineData[k] = bits[7:0];
      end
      if (capture)
      begin
        for (g = 0; g < wordsPerLine; g++)
        begin
          for (k = 0; k < 4; k++)
            word[8*k +: 8] = grayOf({lineData[8*g + 2*k], lineData[8*g + 2*k + 1]});
          expData.push_back(word);
          expAddr.push_back(baseAddr + 32'(4 * (line * wordsPerLine + g)));
        end
      end
      for (k = 0; k < bytesPerLine; k++)
      begin
        hsync   <= 1'b1;
        camData <= lineData[k];
        @(posedge pclk);
      end
      hsync   <= 1'b0;
      camData <= '0;
      repeat (40) @(posedge pclk);
    end
  endtask

  task automatic waitBusIdle(input string phase);
    int waited;
    waited = 0;
    while (((expData.size() != 0) || (slavePhase != 0)) && (waited < drainTimeout))
    begin
      @(posedge clock);
      waited++;
    end
    if ((expData.size() != 0) || (slavePhase != 0))
      reportFailure({"bus writes of the ", phase, " phase did not finish in time"});
  endtask

  // ==========================================================================
  // bus slave
  // ==========================================================================

  always @(posedge clock)
  begin
    busGrant <= 1'b0;
    busy     <= 1'b0;
    case (slavePhase)
      0:
        if (requestBus)
        begin
          drawBits(slaveLfsr, 4, slaveDraw);
          grantDelay = int'(slaveDraw[3:0]);
          slavePhase = 1;
        end
      1:
      begin
        checkValue("requestBus", 32'd1, 32'(requestBus));
        if (grantDelay == 0)
        begin
          busGrant  <= 1'b1;
          slavePhase = 2;
        end
        else
          grantDelay--;
      end
      default:
      begin
        if (beginTransaction)
        begin
          beginCount++;
          curAddr       = addressData;
          burstSizeSeen = burstSize;
          wordsInBurst  = 0;
          burstOpen     = 1'b1;
          // a new line starts once the previous one is used up.
          if (lineWordsLeft == 0)
            lineWordsLeft = wordsPerLine;
          burstExpected = (lineWordsLeft > maxBurst) ? maxBurst : lineWordsLeft;
          lineWordsLeft = lineWordsLeft - burstExpected;
          checkValue("byteEnables", 32'hF, 32'(byteEnables));
          checkValue("burstSize", 32'(burstExpected - 1), 32'(burstSize));
        end
        if (dataValid && !busy)
        begin
          if (expData.size() == 0)
            reportFailure("the DUT wrote a word that no line should produce");
          else
          begin
            checkValue("write address", expAddr.pop_front(), curAddr);
            checkValue("addressData", expData.pop_front(), addressData);
          end
          curAddr = curAddr + 32'd4;
          wordsInBurst++;
          totalWords++;
        end
        if (endTransaction)
        begin
          endCount++;
          checkValue("words in burst", 32'(burstSizeSeen) + 32'd1, 32'(wordsInBurst));
          burstOpen  = 1'b0;
          slavePhase = 0;
        end
        // about one busy cycle in four.
        if (burstOpen)
        begin
          drawBits(slaveLfsr, 2, slaveDraw);
          busy <= &slaveDraw[1:0];
        end
      end
    endcase
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial
  begin
    logic [31:0] result;
    logic        done;
    logic [31:0] bits;
    logic [31:0] fpsExpected;
    int          wordsBefore;
    int          beginsBefore;
    arstN         = 1'b0;
    hsync         = 1'b0;
    vsync         = 1'b0;
    camData       = '0;
    ciStart       = 1'b0;
    ciCke         = 1'b0;
    ciN           = '0;
    ciValueA      = '0;
    ciValueB      = '0;
    busGrant      = 1'b0;
    busy          = 1'b0;
    busError      = 1'b0;
    camLfsr       = 16'd36;
    slaveLfsr     = 16'd36;
    errorCount    = 0;
    cycleCount    = 0;
    slavePhase    = 0;
    burstOpen     = 1'b0;
    lineWordsLeft = 0;
    totalWords    = 0;
    beginCount    = 0;
    endCount      = 0;
    baseAddr      = '0;
    repeat (8) @(posedge clock);
    arstN <= 1'b1;
    repeat (4) @(posedge clock);

    // base register round trip.
    drawBits(camLfsr, 32, bits);
    baseAddr = bits & 32'hFFFF_FFFC;
    issueInstruction(8'(ciId), opWriteBase, bits, result, done);
    checkValue("ciDone on write", 32'd1, 32'(done));
    issueInstruction(8'(ciId), opReadBase, '0, result, done);
    checkValue("ciResult base", baseAddr, result);
    checkValue("ciDone on read", 32'd1, 32'(done));

    // unselected and unused reads.
    issueInstruction(8'(ciId + 1), opReadBase, '0, result, done);
    checkValue("ciResult unselected", 32'd0, result);
    checkValue("ciDone unselected", 32'd0, 32'(done));
    issueInstruction(8'(ciId), opControl, '0, result, done);
    checkValue("ciResult control code", 32'd0, result);
    issueInstruction(8'(ciId), 32'h0000_0104, '0, result, done);
    checkValue("ciResult out of range code", 32'd0, result);

    // continuous grabbing.
    issueInstruction(8'(ciId), opControl, 32'd1, result, done);
    repeat (3) sendFrame(1'b1);
    waitBusIdle("continuous");
    issueInstruction(8'(ciId), opLineBytes, '0, result, done);
    checkValue("lineBytes", 32'(bytesPerLine), result);
    issueInstruction(8'(ciId), opFrameLines, '0, result, done);
    checkValue("frameLines", 32'(linesPerFrame), result);

    // single shot takes the next frame only.
    issueInstruction(8'(ciId), opControl, 32'd2, result, done);
    wordsBefore = totalWords;
    sendFrame(1'b1);
    waitBusIdle("single shot");
    checkValue("single shot words", 32'(linesPerFrame * wordsPerLine),
               32'(totalWords - wordsBefore));
    beginsBefore = beginCount;
    sendFrame(1'b0);
    issueInstruction(8'(ciId), opShotDone, '0, result, done);
    checkValue("shot done first read", 32'd1, result);
    issueInstruction(8'(ciId), opShotDone, '0, result, done);
    checkValue("shot done second read", 32'd0, result);
    checkValue("bursts after shot", 32'(beginsBefore), 32'(beginCount));

    // steady frames across two Hz ticks.
    while (cycleCount < 2 * clockHz + 4 * khzCycles)
      sendFrame(1'b0);
    issueInstruction(8'(ciId), opPclkKhz, '0, result, done);
    if (!withinTolerance(32'd25, result, 1))
      checkValue("pclkKhz", 32'd25, result);
    issueInstruction(8'(ciId), opFps, '0, result, done);
    fpsExpected = 32'(framesInWindow(clockHz, 2 * clockHz));
    if (!withinTolerance(fpsExpected, result, 1))
      checkValue("fps", fpsExpected, result);
    checkValue("endTransaction count", 32'(beginCount), 32'(endCount));

    $display("%0d errors over %0d bursts and %0d words", errorCount, beginCount, totalWords);
    if (errorCount == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* sources.f */
common/cameraPkg.sv
common/grabberCfgIf.sv
src/pulseSync.sv
src/rateMeter.sv
capture/pixelCapture.sv
capture/lineBuffer.sv
src/ciRegisters.sv
src/burstControl.sv
src/cameraGrabber.sv
tests/cameraGrabberTb.sv

/* Makefile */
VERILATOR ?= verilator
SIMFLAGS  ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := cameraGrabberTb
FILELIST  := sources.f
BUILDDIR  := obj_dir
LOG       := sim.log
PASSTEXT  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
